// File: tb.f
verilog/fetch_pkg.sv
verilog/sync_queue.sv
verilog/branch_history_table.sv
verilog/fetch_control.sv
verilog/fetch_unit.sv
tests/tb_clock.sv
tests/fetch_tb.sv

// File: tests/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb
    import fetch_pkg::*;
();

    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 16;
    localparam int RUN_LEN      = 80;
    localparam int SHORT_LEN    = 40;
    localparam int STALL_LIMIT  = 50;
    localparam int MIN_ENTRIES  = 100;
    localparam int TEST_CYCLES  = RESET_CYCLES + 3 * RUN_LEN + 7 * SHORT_LEN +
                                  2 * STALL_LIMIT + 24;

    localparam int KIND_NONE = 0;
    localparam int KIND_JAL  = 1;
    localparam int KIND_BR   = 2;

    localparam int READY_RANDOM = 0;
    localparam int READY_LOW    = 1;
    localparam int READY_HIGH   = 2;

    logic  clk;
    logic  arst_n;
    logic  mem_req_valid;
    logic  mem_req_ready;
    addr_t mem_req_addr;
    logic  mem_resp_valid;
    inst_t mem_resp_data;
    logic  out_valid;
    logic  out_ready;
    addr_t out_addr;
    inst_t out_inst;
    iid_t  out_id;
    logic  redirect_valid;
    addr_t redirect_addr;
    logic  br_update_valid;
    addr_t br_update_pc;
    logic  br_update_taken;

    int    seed = 57;
    int    ready_mode;
    int    resp_wait;
    addr_t resp_addr;

    // reference state
    logic [1:0] bht_model [2**BHT_INDEX_BITS];
    addr_t      exp_addr;
    iid_t       exp_id;
    logic       id_known;
    int         pending;
    int         consumed;
    logic       take;

    tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) tb_clock_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fetch_unit dut_i (.*);

    // planted control flow among op-imm filler
    function automatic int kind_at(addr_t a);
        case (a)
            32'h110, 32'h204, 32'h1310: return KIND_BR;
            32'h140, 32'h20c, 32'h300:  return KIND_JAL;
            default:                    return KIND_NONE;
        endcase
    endfunction

    function automatic int offset_at(addr_t a);
        case (a)
            32'h110:  return 32'h10;
            32'h140:  return -32'h40;
            32'h204:  return -32'h4;
            32'h20c:  return -32'hc;
            32'h300:  return 32'h1000;
            32'h1310: return -32'h810;
            default:  return 4;
        endcase
    endfunction

    function automatic inst_t jal_word(int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], 5'd1, JAL_OP};
    endfunction

    function automatic inst_t branch_word(int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], BR_OP};
    endfunction

    function automatic inst_t word_at(addr_t a);
        case (kind_at(a))
            KIND_JAL: return jal_word(offset_at(a));
            KIND_BR:  return branch_word(offset_at(a));
            default:  return {a[31:7] ^ a[24:0], 7'b0010011};
        endcase
    endfunction

    // address the fetch stage should go to after the word at a
    function automatic addr_t next_addr_of(addr_t a);
        case (kind_at(a))
            KIND_JAL: return a + addr_t'(offset_at(a));
            KIND_BR:  return bht_model[a[7:2]][1] ? a + addr_t'(offset_at(a)) : a + 32'd4;
            default:  return a + 32'd4;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] time %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic send_redirect(input addr_t target, input logic train, input addr_t pc,
                                 input logic taken);
        @(posedge clk);
        #2;
        redirect_valid  = 1'b1;
        redirect_addr   = target;
        br_update_valid = train;
        br_update_pc    = pc;
        br_update_taken = taken;
        @(posedge clk);
        #2;
        redirect_valid  = 1'b0;
        br_update_valid = 1'b0;
    endtask

    task automatic wait_for_stall();
        int n;
        n = 0;
        while (pending < QUEUE_DEPTH) begin
            @(posedge clk);
            n++;
            if (n > STALL_LIMIT) begin
                fail_run("fetch queue never filled while decode was stalled");
            end
        end
    endtask

    // instruction memory and decode side
    always @(posedge clk) begin
        logic  fire;
        logic  in_reset;
        addr_t fire_addr;
        fire      = mem_req_valid && mem_req_ready;
        fire_addr = mem_req_addr;
        in_reset  = !arst_n;
        #2;
        mem_resp_valid = 1'b0;
        if (in_reset) begin
            resp_wait = 0;
        end else begin
            if (fire) begin
                resp_addr = fire_addr;
                resp_wait = 1 + ($unsigned($random(seed)) % 3);
            end
            if (resp_wait > 0) begin
                resp_wait--;
                if (resp_wait == 0) begin
                    mem_resp_valid = 1'b1;
                    mem_resp_data  = word_at(resp_addr);
                end
            end
        end
        case (ready_mode)
            READY_LOW:  out_ready = 1'b0;
            READY_HIGH: out_ready = 1'b1;
            default:    out_ready = ($unsigned($random(seed)) % 4) != 0;
        endcase
    end

    assign take = out_valid && out_ready;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**BHT_INDEX_BITS; i++) begin
                bht_model[i] <= 2'b01;
            end
            exp_addr <= RESET_ADDR;
            exp_id   <= '0;
            id_known <= 1'b1;
            pending  <= 0;
            consumed <= 0;
        end else begin
            if (take) begin
                exp_addr <= next_addr_of(out_addr);
                exp_id   <= out_id + 1'b1;
                id_known <= 1'b1;
                consumed <= consumed + 1;
            end
            // requests issued and not yet consumed
            pending <= pending + int'(mem_req_valid && mem_req_ready) - int'(take);
            if (redirect_valid) begin
                exp_addr <= redirect_addr;
                id_known <= 1'b0;
                pending  <= 0;
            end
            if (br_update_valid) begin
                if (br_update_taken && bht_model[br_update_pc[7:2]] != 2'b11) begin
                    bht_model[br_update_pc[7:2]] <= bht_model[br_update_pc[7:2]] + 2'b01;
                end else if (!br_update_taken && bht_model[br_update_pc[7:2]] != 2'b00) begin
                    bht_model[br_update_pc[7:2]] <= bht_model[br_update_pc[7:2]] - 2'b01;
                end
            end
        end
    end

    a_entry_inst: assert property (@(posedge clk) disable iff (!arst_n)
        take |-> out_inst == word_at(out_addr))
        else report_mismatch("out_inst", word_at($sampled(out_addr)), $sampled(out_inst));

    a_entry_addr: assert property (@(posedge clk) disable iff (!arst_n)
        take |-> out_addr == exp_addr)
        else report_mismatch("out_addr", $sampled(exp_addr), $sampled(out_addr));

    a_entry_id: assert property (@(posedge clk) disable iff (!arst_n)
        take && id_known |-> out_id == exp_id)
        else report_mismatch("out_id", 32'($sampled(exp_id)), 32'($sampled(out_id)));

    a_no_issue_when_backed_up: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && mem_req_ready |-> pending <= QUEUE_DEPTH)
        else fail_run("request issued with a full queue of entries waiting");

    a_redirect_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |-> !mem_req_valid)
        else fail_run("request raised in a redirect cycle");

    a_redirect_flush: assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |=> !out_valid)
        else fail_run("queue not empty after a redirect");

    a_reset_empty: assert property (@(posedge clk) $rose(arst_n) |-> !out_valid)
        else fail_run("out_valid high in the first cycle after reset");

    initial begin
        #(TEST_CYCLES * PERIOD_NS * 4);
        fail_run("watchdog expired before the test sequence finished");
    end

    initial begin
        mem_req_ready   = 1'b1;
        mem_resp_valid  = 1'b0;
        mem_resp_data   = '0;
        out_ready       = 1'b0;
        redirect_valid  = 1'b0;
        redirect_addr   = '0;
        br_update_valid = 1'b0;
        br_update_pc    = '0;
        br_update_taken = 1'b0;
        ready_mode      = READY_RANDOM;
        @(posedge arst_n);

        // loop at 0x100 with its branch not taken
        wait_cycles(RUN_LEN);
        send_redirect(32'h100, 1'b1, 32'h110, 1'b1);
        wait_cycles(RUN_LEN);
        // tight loop at 0x200 taken, then trained back
        send_redirect(32'h200, 1'b1, 32'h204, 1'b1);
        wait_cycles(SHORT_LEN);
        send_redirect(32'h200, 1'b1, 32'h204, 1'b0);
        wait_cycles(SHORT_LEN);
        // long jal, then a backward branch sharing index 4
        send_redirect(32'h300, 1'b0, '0, 1'b0);
        wait_cycles(SHORT_LEN);
        // redirects that land on an outstanding read
        send_redirect(32'h100, 1'b1, 32'h110, 1'b1);
        wait_cycles(3);
        send_redirect(32'h140, 1'b1, 32'h110, 1'b0);
        wait_cycles(SHORT_LEN);

        ready_mode = READY_LOW;
        send_redirect(32'h100, 1'b0, '0, 1'b0);
        wait_for_stall();
        wait_cycles(SHORT_LEN);
        ready_mode = READY_RANDOM;
        wait_cycles(RUN_LEN);
        ready_mode = READY_LOW;
        wait_for_stall();
        wait_cycles(SHORT_LEN);
        ready_mode = READY_HIGH;
        wait_cycles(SHORT_LEN);

        if (consumed < MIN_ENTRIES) begin
            fail_run("too few entries reached the decode side");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release 2 ns after an edge like the other inputs
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
    end

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,

    output logic  mem_req_valid,
    input  logic  mem_req_ready,
    output addr_t mem_req_addr,
    input  logic  mem_resp_valid,
    input  inst_t mem_resp_data,

    output logic  out_valid,
    input  logic  out_ready,
    output addr_t out_addr,
    output inst_t out_inst,
    output iid_t  out_id,

    input  logic  redirect_valid,
    input  addr_t redirect_addr,

    input  logic  br_update_valid,
    input  addr_t br_update_pc,
    input  logic  br_update_taken
);

    logic  q_full;
    logic  q_kill;
    logic  q_wvalid;
    addr_t q_waddr;
    inst_t q_winst;
    iid_t  q_wid;
    addr_t pred_pc;
    logic  pred_taken;

    logic [$bits(addr_t)+$bits(inst_t)+$bits(iid_t)-1:0] q_wdata;
    logic [$bits(addr_t)+$bits(inst_t)+$bits(iid_t)-1:0] q_rdata;

    // queue entry is {addr, inst, id}
    assign q_wdata = {q_waddr, q_winst, q_wid};
    assign {out_addr, out_inst, out_id} = q_rdata;

    fetch_control fetch_control_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_addr   (mem_req_addr),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .q_full         (q_full),
        .q_kill         (q_kill),
        .q_wvalid       (q_wvalid),
        .q_waddr        (q_waddr),
        .q_winst        (q_winst),
        .q_wid          (q_wid),
        .pred_pc        (pred_pc),
        .pred_taken     (pred_taken)
    );

    sync_queue #(
        .WIDTH ($bits(addr_t) + $bits(inst_t) + $bits(iid_t)),
        .DEPTH (QUEUE_DEPTH)
    ) sync_queue_i (
        .clk    (clk),
        .arst_n (arst_n),
        .kill   (q_kill),
        .wvalid (q_wvalid),
        .wdata  (q_wdata),
        .full   (q_full),
        .rready (out_ready),
        .rvalid (out_valid),
        .rdata  (q_rdata)
    );

    branch_history_table branch_history_table_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .pred_pc      (pred_pc),
        .pred_taken   (pred_taken),
        .update_valid (br_update_valid),
        .update_pc    (br_update_pc),
        .update_taken (br_update_taken)
    );

endmodule

// File: verilog/fetch_control.sv
`timescale 1ns/1ns

module fetch_control
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,

    // instruction memory
    output logic  mem_req_valid,
    input  logic  mem_req_ready,
    output addr_t mem_req_addr,
    input  logic  mem_resp_valid,
    input  inst_t mem_resp_data,

    // redirect from execute
    input  logic  redirect_valid,
    input  addr_t redirect_addr,

    // fetch queue write side
    input  logic  q_full,
    output logic  q_kill,
    output logic  q_wvalid,
    output addr_t q_waddr,
    output inst_t q_winst,
    output iid_t  q_wid,

    // branch predictor
    output addr_t pred_pc,
    input  logic  pred_taken
);

    fetch_state_t state;

    addr_t fetch_pc;
    addr_t req_addr;
    iid_t  req_id;
    iid_t  id_cnt;

    // response parked when it lands on a full queue
    logic  hold_valid;
    addr_t hold_addr;
    inst_t hold_inst;
    iid_t  hold_id;

    logic       resp_accept;
    logic       req_fire;
    logic [6:0] opcode;
    logic       is_jal;
    logic       is_br;
    addr_t      imm_j;
    addr_t      imm_b;
    addr_t      next_addr;

    assign resp_accept = state == WAIT_RESP && mem_resp_valid && !redirect_valid;
    assign req_fire    = mem_req_valid && mem_req_ready;

    // predecode of the word coming back
    assign opcode = mem_resp_data[6:0];
    assign is_jal = opcode == JAL_OP;
    assign is_br  = opcode == BR_OP;

    assign imm_j = {{12{mem_resp_data[31]}}, mem_resp_data[19:12], mem_resp_data[20],
                    mem_resp_data[30:21], 1'b0};
    assign imm_b = {{20{mem_resp_data[31]}}, mem_resp_data[7], mem_resp_data[30:25],
                    mem_resp_data[11:8], 1'b0};

    // predictor looks up the address being returned
    assign pred_pc = req_addr;

    assign next_addr = is_jal              ? req_addr + imm_j :
                       is_br && pred_taken ? req_addr + imm_b :
                                             req_addr + 32'd4;

    // back to back issue only in the response cycle
    assign mem_req_valid = !redirect_valid && !q_full && !hold_valid &&
                           (state == IDLE || (state == WAIT_RESP && mem_resp_valid));
    assign mem_req_addr  = (state == WAIT_RESP) ? next_addr : fetch_pc;

    assign q_kill   = redirect_valid;
    assign q_wvalid = !q_full && (hold_valid || resp_accept);
    assign q_waddr  = hold_valid ? hold_addr : req_addr;
    assign q_winst  = hold_valid ? hold_inst : mem_resp_data;
    assign q_wid    = hold_valid ? hold_id : req_id;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            fetch_pc   <= RESET_ADDR;
            id_cnt     <= '0;
            hold_valid <= 1'b0;
        end else if (redirect_valid) begin
            fetch_pc   <= redirect_addr;
            hold_valid <= 1'b0;
            // a read still out there must be dropped
            if (state != IDLE && !mem_resp_valid) begin
                state <= DISCARD;
            end else begin
                state <= IDLE;
            end
        end else begin
            if (req_fire) begin
                id_cnt <= id_cnt + 1'b1;
            end

            if (hold_valid && !q_full) begin
                hold_valid <= 1'b0;
            end else if (resp_accept && q_full) begin
                hold_valid <= 1'b1;
            end

            case (state)
                IDLE: begin
                    if (req_fire) begin
                        state <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (mem_resp_valid && !req_fire) begin
                        state    <= IDLE;
                        fetch_pc <= next_addr;
                    end
                end
                DISCARD: begin
                    if (mem_resp_valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request and parked response payload
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_addr <= mem_req_addr;
            req_id   <= id_cnt;
        end
        if (resp_accept && q_full) begin
            hold_addr <= req_addr;
            hold_inst <= mem_resp_data;
            hold_id   <= req_id;
        end
    end

    // a parked response means no read is in flight
    a_parked_when_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        hold_valid |-> state == IDLE
    ) else $error("fetch_control: read in flight while a response is parked");

    a_resp_expected: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_resp_valid |-> state != IDLE
    ) else $error("fetch_control: response with no read outstanding");

endmodule

// File: verilog/branch_history_table.sv
`timescale 1ns/1ns

module branch_history_table
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,

    // combinational predict side
    input  addr_t pred_pc,
    output logic  pred_taken,

    // training from execute
    input  logic  update_valid,
    input  addr_t update_pc,
    input  logic  update_taken
);

    logic [1:0]                ctr [2**BHT_INDEX_BITS];
    logic [BHT_INDEX_BITS-1:0] pred_idx;
    logic [BHT_INDEX_BITS-1:0] upd_idx;
    logic [1:0]                upd_ctr;

    // word aligned, so skip bits 1:0
    assign pred_idx = pred_pc[BHT_INDEX_BITS+1:2];
    assign upd_idx  = update_pc[BHT_INDEX_BITS+1:2];

    assign pred_taken = ctr[pred_idx][1];
    assign upd_ctr    = ctr[upd_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // weakly not-taken
            for (int i = 0; i < 2**BHT_INDEX_BITS; i++) begin
                ctr[i] <= 2'b01;
            end
        end else if (update_valid) begin
            if (update_taken) begin
                if (upd_ctr != 2'b11) begin
                    ctr[upd_idx] <= upd_ctr + 2'b01;
                end
            end else begin
                if (upd_ctr != 2'b00) begin
                    ctr[upd_idx] <= upd_ctr - 2'b01;
                end
            end
        end
    end

endmodule

// File: verilog/sync_queue.sv
`timescale 1ns/1ns

module sync_queue #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             arst_n,

    input  logic             kill,

    input  logic             wvalid,
    input  logic [WIDTH-1:0] wdata,
    output logic             full,

    input  logic             rready,
    output logic             rvalid,
    output logic [WIDTH-1:0] rdata
);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       wr_en;
    logic                       rd_en;

    assign full   = count == DEPTH;
    assign rvalid = count != 0;
    assign rdata  = mem[rd_ptr];

    assign wr_en = wvalid && !full;
    assign rd_en = rready && rvalid;

    // entry storage
    always_ff @(posedge clk) begin
        if (wr_en && !kill) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (kill) begin
            // flush drops everything queued
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // producer must hold off once the queue is full
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        wvalid && full |-> kill
    ) else $error("sync_queue: write while full");

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

    // instruction address
    typedef logic [31:0] addr_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // one fetch id per issued request
    typedef logic [7:0] iid_t;

    // fetch control states
    typedef enum logic [1:0] {
        IDLE,
        WAIT_RESP,
        DISCARD
    } fetch_state_t;

    // first fetch after reset
    localparam addr_t RESET_ADDR = 32'h0000_0100;

    // entries in the fetch queue
    localparam int QUEUE_DEPTH = 8;

    // predictor index over address bits 7:2
    localparam int BHT_INDEX_BITS = 6;

    // rv32 opcodes seen by predecode
    localparam logic [6:0] JAL_OP = 7'b1101111;
    localparam logic [6:0] BR_OP  = 7'b1100011;

endpackage
